//--- filelist.f
+incdir+hw
hw/imuldiv_arith_pkg.sv
hw/imuldiv_bus_pkg.sv
hw/imuldiv_mul_dpath.sv
hw/imuldiv_div_dpath.sv
hw/imuldiv_ctrl.sv
hw/imuldiv_top.sv
sim/imuldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=imuldiv_tb
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  -f filelist.f \
  --top-module "$TOP" \
  -o "$TOP"

# a failing run stops in $fatal, the log is searched afterwards
./obj_dir/"$TOP" 2>&1 | tee "$LOG" || true

if grep -q "Simulation failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

//--- sim/imuldiv_tb.sv
//--------------------------------------------------------------------
// multiply/divide unit testbench
// Wishbone tasks, a directed table loop and a seeded random loop
//--------------------------------------------------------------------

`timescale 1ns/100ps

module imuldiv_tb
  import imuldiv_arith_pkg::*, imuldiv_bus_pkg::*;
();

  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 100;
  localparam int NUM_VEC     = 17;
  localparam int NUM_RANDOM  = 200;

  // one directed entry, exp holds {hi, lo} as read from the bus
  typedef struct packed {
    imuldiv_op_e op;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] exp;
  } vector_t;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;

  vector_t     vectors [NUM_VEC];
  logic [31:0] rng_state;

  imuldiv_top imuldiv_top_inst (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .sel   (sel),
    .dat_r (dat_r),
    .ack   (ack)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //------------------------------------------------------------------
  // checking and reference model
  //------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // {hi, lo} as the unit should report it, divides give {rem, quot}
  function automatic logic [63:0] expected_result(input imuldiv_op_e op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    int     sa;
    int     sb;
    longint sp;
    sa = a;
    sb = b;
    case (op)
      OP_MUL: begin
        sp = longint'(sa) * longint'(sb);
        return sp;
      end
      OP_MULU: return {32'd0, a} * {32'd0, b};
      OP_DIV: begin
        if (b == 32'd0) return {a, 32'hFFFF_FFFF};
        // most negative over -1 wraps back to itself
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return {32'd0, 32'h8000_0000};
        // SV division truncates toward zero, remainder follows dividend
        return {sa % sb, sa / sb};
      end
      default: begin
        if (b == 32'd0) return {a, 32'hFFFF_FFFF};
        return {a % b, a / b};
      end
    endcase
  endfunction

  //------------------------------------------------------------------
  // Wishbone master, called on a falling edge
  //------------------------------------------------------------------

  task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
    int waited;
    waited = 0;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    sel   = 4'hF;
    @(negedge clk);
    while (!ack) begin
      waited++;
      if (waited > ACK_TIMEOUT) abort_run("no ack for a write cycle");
      @(negedge clk);
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] a, output logic [31:0] d);
    int waited;
    waited = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    @(negedge clk);
    while (!ack) begin
      waited++;
      if (waited > ACK_TIMEOUT) abort_run("no ack for a read cycle");
      @(negedge clk);
    end
    // dat_r is valid while ack is high
    d   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic poll_done();
    logic [31:0] status;
    int          polls;
    polls = 0;
    wb_read(REG_STATUS, status);
    while (!status[STATUS_DONE_BIT]) begin
      polls++;
      if (polls >= POLL_LIMIT) abort_run("done flag never set after a start");
      wb_read(REG_STATUS, status);
    end
  endtask

  task automatic start_op(input imuldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    wb_write(REG_OPA, a);
    wb_write(REG_OPB, b);
    wb_write(REG_CTRL, (32'd1 << CTRL_START_BIT) | {30'd0, op});
  endtask

  task automatic run_and_check(input string name, input imuldiv_op_e op,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    start_op(op, a, b);
    poll_done();
    wb_read(REG_RES_LO, lo);
    wb_read(REG_RES_HI, hi);
    check_word({name, " lo"}, exp[31:0], lo);
    check_word({name, " hi"}, exp[63:32], hi);
  endtask

  task automatic load_vectors();
    // multiplies, signed then unsigned
    vectors[0]  = '{OP_MUL,  32'h0000_0007, 32'hFFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFEB};
    vectors[1]  = '{OP_MUL,  32'h1234_5678, 32'h0000_0000, 64'h0000_0000_0000_0000};
    vectors[2]  = '{OP_MUL,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001};
    vectors[3]  = '{OP_MUL,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000};
    vectors[4]  = '{OP_MULU, 32'h0000_0007, 32'hFFFF_FFFD, 64'h0000_0006_FFFF_FFEB};
    vectors[5]  = '{OP_MULU, 32'h0000_0000, 32'hFFFF_FFFF, 64'h0000_0000_0000_0000};
    vectors[6]  = '{OP_MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001};
    vectors[7]  = '{OP_MULU, 32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000};
    // divides, {rem, quot}
    vectors[8]  = '{OP_DIV,  32'h0000_0007, 32'hFFFF_FFFE, 64'h0000_0001_FFFF_FFFD};
    vectors[9]  = '{OP_DIV,  32'hFFFF_FFF9, 32'h0000_0002, 64'hFFFF_FFFF_FFFF_FFFD};
    vectors[10] = '{OP_DIV,  32'hFFFF_FFF9, 32'hFFFF_FFFE, 64'hFFFF_FFFF_0000_0003};
    vectors[11] = '{OP_DIV,  32'hFFFF_FFFB, 32'h0000_0000, 64'hFFFF_FFFB_FFFF_FFFF};
    vectors[12] = '{OP_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000};
    vectors[13] = '{OP_DIVU, 32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000E};
    vectors[14] = '{OP_DIVU, 32'hFFFF_FFFF, 32'h0000_0002, 64'h0000_0001_7FFF_FFFF};
    vectors[15] = '{OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 64'h8000_0000_0000_0000};
    vectors[16] = '{OP_DIVU, 32'h0000_0005, 32'h0000_0000, 64'h0000_0005_FFFF_FFFF};
  endtask

  //------------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------------

  initial begin
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    imuldiv_op_e op;
    clk       = 1'b0;
    reset     = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = 3'd0;
    dat_w     = 32'd0;
    sel       = 4'h0;
    rng_state = 32'h15f0;
    load_vectors();

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // idle state after reset
    wb_read(REG_STATUS, word);
    check_word("reset status", 32'd0, word);
    wb_read(REG_RES_LO, word);
    check_word("reset res_lo", 32'd0, word);
    wb_read(REG_RES_HI, word);
    check_word("reset res_hi", 32'd0, word);
    wb_write(REG_OPA, 32'hA5A5_0F0F);
    wb_write(REG_OPB, 32'h1234_8765);
    wb_read(REG_OPA, word);
    check_word("opa readback", 32'hA5A5_0F0F, word);
    wb_read(REG_OPB, word);
    check_word("opb readback", 32'h1234_8765, word);

    for (int i = 0; i < NUM_VEC; i++) begin
      run_and_check($sformatf("table %0d", i), vectors[i].op, vectors[i].a,
                    vectors[i].b, vectors[i].exp);
    end

    // busy right after start, a second start is dropped
    start_op(OP_MULU, 32'd1000, 32'd3000);
    wb_read(REG_STATUS, word);
    check_word("status busy", 32'd1 << STATUS_BUSY_BIT, word);
    start_op(OP_DIVU, 32'd77, 32'd5);
    poll_done();
    wb_read(REG_RES_LO, word);
    check_word("ignored start lo", 32'd3000000, word);
    wb_read(REG_RES_HI, word);
    check_word("ignored start hi", 32'd0, word);
    wb_read(REG_STATUS, word);
    check_word("status done", 32'd1 << STATUS_DONE_BIT, word);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      a         = rng_state;
      rng_state = xorshift32(rng_state);
      b         = rng_state;
      rng_state = xorshift32(rng_state);
      pick      = rng_state;
      op        = imuldiv_op_e'(pick[1:0]);
      // zero, small divisors and the overflow pair now and then
      if (pick[4:2] == 3'd0) begin
        b = 32'd0;
      end else if (pick[4:2] == 3'd1) begin
        b = {28'd0, pick[11:8]};
      end else if (pick[4:2] == 3'd2) begin
        a = 32'h8000_0000;
        b = 32'hFFFF_FFFF;
      end
      run_and_check($sformatf("random %0d", i), op, a, b, expected_result(op, a, b));
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- hw/imuldiv_top.sv
//--------------------------------------------------------------------
// iterative multiply/divide unit with a Wishbone classic slave port
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "imuldiv_defines.svh"

module imuldiv_top
  import imuldiv_arith_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`IMULDIV_ADR_W-1:0] adr,
  input  imuldiv_word_t             dat_w,
  input  logic [3:0]                sel,
  output imuldiv_word_t             dat_r,
  output logic                      ack
);

  // shared operands and strobes
  imuldiv_word_t  opa;
  imuldiv_word_t  opb;
  logic           is_signed;
  logic           load;
  logic           step;
  logic           fix;
  // datapath results
  imuldiv_dword_t mul_product;
  imuldiv_word_t  div_quot;
  imuldiv_word_t  div_rem;

  imuldiv_ctrl imuldiv_ctrl_inst (
    .clk         (clk),
    .reset       (reset),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .dat_w       (dat_w),
    .sel         (sel),
    .dat_r       (dat_r),
    .ack         (ack),
    .opa         (opa),
    .opb         (opb),
    .is_signed   (is_signed),
    .load        (load),
    .step        (step),
    .fix         (fix),
    .mul_product (mul_product),
    .div_quot    (div_quot),
    .div_rem     (div_rem)
  );

  imuldiv_mul_dpath imuldiv_mul_dpath_inst (
    .clk       (clk),
    .reset     (reset),
    .opa       (opa),
    .opb       (opb),
    .is_signed (is_signed),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .product   (mul_product)
  );

  imuldiv_div_dpath imuldiv_div_dpath_inst (
    .clk       (clk),
    .reset     (reset),
    .opa       (opa),
    .opb       (opb),
    .is_signed (is_signed),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .quot      (div_quot),
    .rem       (div_rem)
  );

endmodule

//--- hw/imuldiv_ctrl.sv
//--------------------------------------------------------------------
// multiply/divide control
// Wishbone slave, operand registers and the load/step/fix sequencer
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "imuldiv_defines.svh"

module imuldiv_ctrl
  import imuldiv_arith_pkg::*, imuldiv_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  // Wishbone classic slave
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`IMULDIV_ADR_W-1:0] adr,
  input  imuldiv_word_t             dat_w,
  input  logic [3:0]                sel,
  output imuldiv_word_t             dat_r,
  output logic                      ack,
  // datapath control
  output imuldiv_word_t             opa,
  output imuldiv_word_t             opb,
  output logic                      is_signed,
  output logic                      load,
  output logic                      step,
  output logic                      fix,
  // datapath results
  input  imuldiv_dword_t            mul_product,
  input  imuldiv_word_t             div_quot,
  input  imuldiv_word_t             div_rem
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_FIX
  } state_e;

  state_e          state;
  logic [4:0]      iter_cnt;
  logic            done;
  logic            busy;
  imuldiv_op_e     opcode;
  imuldiv_result_u result;
  imuldiv_result_u result_sel;
  imuldiv_word_t   rd_data;
  logic            bus_req;
  logic            bus_wr;
  logic            start_ok;

  //------------------------------------------------------------------
  // bus decode
  //------------------------------------------------------------------

  // new cycle seen while ack is low, ack follows on the next edge
  assign bus_req = cyc && stb && !ack;
  assign bus_wr  = bus_req && we;
  // sel is not decoded, every write covers the full word

  // start only takes effect when the unit is idle
  assign start_ok = bus_wr && (adr == REG_CTRL) && dat_w[CTRL_START_BIT] && !busy;

  assign busy      = (state != S_IDLE);
  assign is_signed = (opcode == OP_MUL) || (opcode == OP_DIV);

  // the load cycle is spent in RUN with the counter held
  assign step = (state == S_RUN) && !load;
  assign fix  = (state == S_FIX);

  // pick the datapath that matches the opcode
  always_comb begin
    if ((opcode == OP_DIV) || (opcode == OP_DIVU)) begin
      result_sel.div.quot = div_quot;
      result_sel.div.rem  = div_rem;
    end else begin
      result_sel.prod = mul_product;
    end
  end

  // read mux, unmapped offsets give zero
  always_comb begin
    rd_data = '0;
    case (imuldiv_reg_e'(adr))
      REG_OPA:    rd_data = opa;
      REG_OPB:    rd_data = opb;
      REG_CTRL:   rd_data[CTRL_OP_W-1:0] = opcode;
      REG_STATUS: begin
        rd_data[STATUS_BUSY_BIT] = busy;
        rd_data[STATUS_DONE_BIT] = done;
      end
      REG_RES_LO: rd_data = result.prod.lo;
      REG_RES_HI: rd_data = result.prod.hi;
      default:    rd_data = '0;
    endcase
  end

  //------------------------------------------------------------------
  // registers and sequencer
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ack      <= 1'b0;
      opa      <= '0;
      opb      <= '0;
      opcode   <= OP_MUL;
      result   <= '0;
      state    <= S_IDLE;
      iter_cnt <= '0;
      load     <= 1'b0;
      done     <= 1'b0;
    end else begin
      ack  <= bus_req;
      load <= 1'b0;

      // operand writes land even while busy, the datapaths copied theirs
      if (bus_wr && (adr == REG_OPA)) begin
        opa <= dat_w;
      end
      if (bus_wr && (adr == REG_OPB)) begin
        opb <= dat_w;
      end

      if (start_ok) begin
        opcode   <= imuldiv_op_e'(dat_w[CTRL_OP_W-1:0]);
        load     <= 1'b1;
        done     <= 1'b0;
        state    <= S_RUN;
        iter_cnt <= 5'(`IMULDIV_ITERS - 1);
      end else begin
        case (state)
          S_RUN: begin
            // last step when the counter reaches zero
            if (!load) begin
              if (iter_cnt == '0) begin
                state <= S_FIX;
              end else begin
                iter_cnt <= iter_cnt - 5'd1;
              end
            end
          end
          S_FIX: begin
            result <= result_sel;
            done   <= 1'b1;
            state  <= S_IDLE;
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (bus_req && !we) begin
      dat_r <= rd_data;
    end
  end

endmodule

//--- hw/imuldiv_div_dpath.sv
//--------------------------------------------------------------------
// restoring divider datapath
// one quotient bit per step, signs and divide-by-zero applied at fix
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "imuldiv_defines.svh"

module imuldiv_div_dpath
  import imuldiv_arith_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_word_t opa,
  input  imuldiv_word_t opb,
  input  logic          is_signed,
  input  logic          load,
  input  logic          step,
  input  logic          fix,
  output imuldiv_word_t quot,
  output imuldiv_word_t rem
);

  localparam int MSB = `IMULDIV_XLEN - 1;

  imuldiv_word_t           mag_a;
  imuldiv_word_t           mag_b;
  imuldiv_word_t           dvs;
  imuldiv_word_t           dvd_orig;
  imuldiv_word_t           qd;
  imuldiv_word_t           part;
  logic [`IMULDIV_XLEN:0]  shifted;
  logic [`IMULDIV_XLEN:0]  diff;
  logic                    fits;
  logic                    div_zero;
  logic                    q_neg;
  logic                    r_neg;
  imuldiv_word_t           quot_fixed;
  imuldiv_word_t           rem_fixed;

  assign mag_a = (is_signed && opa[MSB]) ? -opa : opa;
  assign mag_b = (is_signed && opb[MSB]) ? -opb : opb;

  // bring down the next dividend bit, then trial subtract
  assign shifted = {part, qd[MSB]};
  assign diff    = shifted - {1'b0, dvs};
  // no borrow means the divisor fits
  assign fits    = !diff[`IMULDIV_XLEN];

  // zero divisor is seen from the stored magnitude
  assign div_zero = (dvs == '0);

  // -2^31 / -1 needs no special case, negation wraps to -2^31
  assign quot_fixed = div_zero ? '1 : (q_neg ? -qd : qd);
  assign rem_fixed  = div_zero ? dvd_orig : (r_neg ? -part : part);

  // corrected values during fix, held in the registers afterwards
  assign quot = fix ? quot_fixed : qd;
  assign rem  = fix ? rem_fixed : part;

  // result signs, remainder follows the dividend
  always_ff @(posedge clk) begin
    if (reset) begin
      q_neg <= 1'b0;
      r_neg <= 1'b0;
    end else if (load) begin
      q_neg <= is_signed && (opa[MSB] ^ opb[MSB]);
      r_neg <= is_signed && opa[MSB];
    end else if (fix) begin
      q_neg <= 1'b0;
      r_neg <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // qd starts as the dividend and fills with quotient bits
      qd       <= mag_a;
      dvs      <= mag_b;
      dvd_orig <= opa;
      part     <= '0;
    end else if (step) begin
      part <= fits ? diff[MSB:0] : shifted[MSB:0];
      qd   <= {qd[MSB-1:0], fits};
    end else if (fix) begin
      qd   <= quot_fixed;
      part <= rem_fixed;
    end
  end

endmodule

//--- hw/imuldiv_mul_dpath.sv
//--------------------------------------------------------------------
// shift-and-add multiplier datapath
// one partial product per step on operand magnitudes, sign set at fix
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "imuldiv_defines.svh"

module imuldiv_mul_dpath
  import imuldiv_arith_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  imuldiv_word_t  opa,
  input  imuldiv_word_t  opb,
  input  logic           is_signed,
  input  logic           load,
  input  logic           step,
  input  logic           fix,
  output imuldiv_dword_t product
);

  localparam int MSB = `IMULDIV_XLEN - 1;

  imuldiv_word_t  mag_a;
  imuldiv_word_t  mag_b;
  imuldiv_dword_t mcand;
  imuldiv_word_t  mplier;
  imuldiv_dword_t acc;
  imuldiv_dword_t acc_fixed;
  logic           neg;

  // strip signs only for the signed opcode
  assign mag_a = (is_signed && opa[MSB]) ? -opa : opa;
  assign mag_b = (is_signed && opb[MSB]) ? -opb : opb;

  assign acc_fixed = neg ? -acc : acc;

  // corrected value shows during the fix cycle so control can latch it
  assign product = fix ? acc_fixed : acc;

  // product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      neg <= 1'b0;
    end else if (load) begin
      neg <= is_signed && (opa[MSB] ^ opb[MSB]);
    end else if (fix) begin
      neg <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // multiplicand widened so it can shift the full 64 bits
      mcand  <= {{`IMULDIV_XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (step) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (fix) begin
      acc <= acc_fixed;
    end
  end

endmodule

//--- hw/imuldiv_bus_pkg.sv
//--------------------------------------------------------------------
// multiply/divide Wishbone register map
// word offsets and bit positions in the CTRL and STATUS words
//--------------------------------------------------------------------

`include "imuldiv_defines.svh"

package imuldiv_bus_pkg;

  // word offsets, 6 and 7 are unmapped and read as zero
  typedef enum logic [`IMULDIV_ADR_W-1:0] {
    REG_OPA    = 3'd0,
    REG_OPB    = 3'd1,
    REG_CTRL   = 3'd2,
    REG_STATUS = 3'd3,
    REG_RES_LO = 3'd4,
    REG_RES_HI = 3'd5
  } imuldiv_reg_e;

  // CTRL word layout, opcode sits at the bottom
  localparam int CTRL_OP_W      = 2;
  localparam int CTRL_START_BIT = 4;

  // STATUS word flags
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

//--- hw/imuldiv_arith_pkg.sv
//--------------------------------------------------------------------
// multiply/divide arithmetic types
// opcodes, data words and the two-way result union
//--------------------------------------------------------------------

`include "imuldiv_defines.svh"

package imuldiv_arith_pkg;

  // operand and double-width words
  typedef logic [`IMULDIV_XLEN-1:0]   imuldiv_word_t;
  typedef logic [2*`IMULDIV_XLEN-1:0] imuldiv_dword_t;

  // operation codes as written to CTRL[1:0]
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } imuldiv_op_e;

  // multiply view, full product
  typedef struct packed {
    imuldiv_word_t hi;
    imuldiv_word_t lo;
  } imuldiv_prod_t;

  // divide view, remainder on top and quotient below
  typedef struct packed {
    imuldiv_word_t rem;
    imuldiv_word_t quot;
  } imuldiv_divres_t;

  typedef union packed {
    imuldiv_prod_t   prod;
    imuldiv_divres_t div;
  } imuldiv_result_u;

endpackage

//--- hw/imuldiv_defines.svh
//--------------------------------------------------------------------
// multiply/divide unit global sizes
// operand width, iteration count and bus word-address width
//--------------------------------------------------------------------

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width, the result is twice this
`define IMULDIV_XLEN 32

// one iteration step per operand bit
`define IMULDIV_ITERS 32

// word-address bits decoded on the bus
`define IMULDIV_ADR_W 3

`endif
